// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_collider -o sim_collider
	./obj_dir/sim_collider > sim.log 2>&1; cat sim.log
	@! grep -q "RESULT: FAIL" sim.log
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/d2q9_pkg.sv
package d2q9_pkg;

    // Lattice directions, also the slot order of every population vector
    typedef enum logic [3:0] {
        DIR_NULL,
        DIR_N,
        DIR_NE,
        DIR_E,
        DIR_SE,
        DIR_S,
        DIR_SW,
        DIR_W,
        DIR_NW
    } dir_e;

    localparam int NUM_DIRS = 9;

    typedef lbm_fixed_pkg::q_t [NUM_DIRS-1:0] pop_vec_t;

    // Lattice weights in Q3.13
    localparam lbm_fixed_pkg::q_t W_REST = 16'sh0E39;
    localparam lbm_fixed_pkg::q_t W_AXIS = 16'sh038E;
    localparam lbm_fixed_pkg::q_t W_DIAG = 16'sh00E4;

    // ----------------------------------------------------------------------
    // Pipeline depths per block
    // ----------------------------------------------------------------------
    localparam int MOMENTS_STAGES     = 2;
    localparam int VELOCITY_STAGES    = 8;
    localparam int EQUILIBRIUM_STAGES = 5;
    localparam int RELAX_STAGES       = 2;
    localparam int PIPE_STAGES        = MOMENTS_STAGES + VELOCITY_STAGES +
                                        EQUILIBRIUM_STAGES + RELAX_STAGES;

endpackage

// File: common/lbm_fixed_pkg.sv
package lbm_fixed_pkg;

    // Q3.13 signed fixed point
    localparam int FRAC_BITS = 13;

    typedef logic signed [15:0] q_t;
    typedef logic signed [31:0] q_wide_t;

    // ----------------------------------------------------------------------
    // Constants
    // ----------------------------------------------------------------------
    localparam q_t Q_ONE           = 16'sh2000;
    localparam q_t Q_TWO           = 16'sh4000;
    localparam q_t Q_THREE         = 16'sh6000;
    localparam q_t Q_THREE_HALVES  = 16'sh3000;
    localparam q_t Q_NINE_QUARTERS = 16'sh4800;

    // Full-precision product, then back to Q3.13 with wrap
    function automatic q_t q_mul(q_t a, q_t b);
        q_wide_t p;
        p = a * b;
        return q_t'(p >>> FRAC_BITS);
    endfunction

endpackage

// File: dv/collider_checker.sv
`timescale 1ns/1ps

module collider_checker #(
    parameter int NAME_CHARS = 24
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    out_valid,
    input  d2q9_pkg::pop_vec_t      f_out,
    input  lbm_fixed_pkg::q_t       rho,
    input  lbm_fixed_pkg::q_t       u_x,
    input  lbm_fixed_pkg::q_t       u_y,
    input  logic                    exp_push,
    input  logic [8*NAME_CHARS-1:0] exp_name,
    input  logic [3:0]              exp_mask,
    input  d2q9_pkg::pop_vec_t      exp_f,
    input  lbm_fixed_pkg::q_t       exp_rho,
    input  lbm_fixed_pkg::q_t       exp_ux,
    input  lbm_fixed_pkg::q_t       exp_uy,
    input  logic                    issue_done,
    output logic                    check_done,
    output int                      fail_count
);
    import lbm_fixed_pkg::*;
    import d2q9_pkg::*;

    localparam int TIMEOUT     = 4 * PIPE_STAGES;
    localparam int RESET_LIMIT = 20;

    typedef struct {
        logic [8*NAME_CHARS-1:0] name;
        logic [3:0]              mask;
        pop_vec_t                f;
        q_t                      rho;
        q_t                      ux;
        q_t                      uy;
    } expect_t;

    expect_t pending_q [$];
    int      tests_run;
    int      tests_failed;

    always @(posedge clk) begin
        if (exp_push) begin
            pending_q.push_back('{exp_name, exp_mask, exp_f, exp_rho, exp_ux, exp_uy});
        end
    end

    task automatic compare_q(input string sig, input q_t expv, input q_t got, inout int errs);
        if (got !== expv) begin
            $display("Error: %s expected %h got %h", sig, expv, got);
            errs++;
        end
    endtask

    task automatic report_test(input logic [8*NAME_CHARS-1:0] name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %0s: ok", name);
        end else begin
            $display("test %0s: %0d mismatches", name, errs);
            tests_failed++;
            fail_count++;
        end
    endtask

    initial begin
        expect_t cur;
        int      n;
        int      idle;
        int      errs;
        logic    abort;

        check_done   = 1'b0;
        fail_count   = 0;
        tests_run    = 0;
        tests_failed = 0;
        abort        = 1'b0;
        errs         = 0;

        n = 0;
        while (rst !== 1'b0 && n < RESET_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            fail_count++;
            abort = 1'b1;
        end else begin
            compare_q("out_valid", 16'(0), 16'(out_valid), errs);
            for (int i = 0; i < NUM_DIRS; i++) begin
                compare_q($sformatf("f_out[%0d]", i), '0, f_out[i], errs);
            end
            compare_q("rho", '0, rho, errs);
            compare_q("u_x", '0, u_x, errs);
            compare_q("u_y", '0, u_y, errs);
            report_test("reset_state", errs);
        end

        idle = 0;
        while (!abort && !(issue_done && pending_q.size() == 0)) begin
            @(negedge clk);
            if (out_valid) begin
                idle = 0;
                if (pending_q.size() == 0) begin
                    $display("an output arrived with no test waiting for it");
                    fail_count++;
                end else begin
                    cur = pending_q.pop_front();
                    errs = 0;
                    if (cur.mask[0]) begin
                        for (int i = 0; i < NUM_DIRS; i++) begin
                            compare_q($sformatf("f_out[%0d]", i), cur.f[i], f_out[i], errs);
                        end
                    end
                    if (cur.mask[1]) begin
                        compare_q("rho", cur.rho, rho, errs);
                    end
                    if (cur.mask[2]) begin
                        compare_q("u_x", cur.ux, u_x, errs);
                    end
                    if (cur.mask[3]) begin
                        compare_q("u_y", cur.uy, u_y, errs);
                    end
                    report_test(cur.name, errs);
                end
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    if (pending_q.size() > 0) begin
                        $display("no output arrived for test %0s", pending_q[0].name);
                    end else begin
                        $display("stimulus did not finish within %0d cycles", TIMEOUT);
                    end
                    fail_count++;
                    abort = 1'b1;
                end
            end
        end

        $display("tests run: %0d, passed: %0d, failed: %0d, other failures: %0d",
                 tests_run, tests_run - tests_failed, tests_failed,
                 fail_count - tests_failed);
        check_done = 1'b1;
    end

endmodule

// File: dv/collider_properties.sv
`timescale 1ns/1ps

module collider_properties (
    input logic                clk,
    input logic                rst,
    input logic                in_valid,
    input logic                out_valid,
    input d2q9_pkg::pop_vec_t  f_out,
    input lbm_fixed_pkg::q_t   rho,
    input lbm_fixed_pkg::q_t   u_x,
    input lbm_fixed_pkg::q_t   u_y
);
    import d2q9_pkg::*;

    // Edges seen since reset release, saturating
    logic [7:0] since_rst;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            since_rst <= '0;
        end else if (since_rst < 8'(PIPE_STAGES)) begin
            since_rst <= since_rst + 8'd1;
        end
    end

    assert property (@(posedge clk) rst |-> !out_valid)
        else $error("out_valid high during reset");

    assert property (@(posedge clk) disable iff (rst)
                     (since_rst < 8'(PIPE_STAGES)) |-> !out_valid)
        else $error("out_valid high before the pipeline could fill");

    assert property (@(posedge clk) disable iff (rst)
                     out_valid == $past(in_valid, PIPE_STAGES))
        else $error("out_valid does not follow in_valid");

    assert property (@(posedge clk) disable iff (rst)
                     out_valid |-> !$isunknown({f_out, rho, u_x, u_y}))
        else $error("unknown output while out_valid is high");

endmodule

bind collider_top collider_properties i_collider_properties (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .f_out     (f_out),
    .rho       (rho),
    .u_x       (u_x),
    .u_y       (u_y)
);

// File: dv/tb_collider.sv
`timescale 1ns/1ps

module tb_collider;
    import lbm_fixed_pkg::*;
    import d2q9_pkg::*;

    localparam int NAME_CHARS = 24;
    localparam int MASK_F     = 0;
    localparam int MASK_RHO   = 1;
    localparam int MASK_UX    = 2;
    localparam int MASK_UY    = 3;
    localparam int DONE_LIMIT = 2000;

    typedef struct {
        logic [8*NAME_CHARS-1:0] name;
        int                      gap;
        q_t                      omega;
        pop_vec_t                f;
        logic [3:0]              mask;
        pop_vec_t                exp_f;
        q_t                      exp_rho;
        q_t                      exp_ux;
        q_t                      exp_uy;
    } entry_t;

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    logic                    in_valid = 1'b0;
    q_t                      omega = '0;
    pop_vec_t                f_in = '0;
    logic                    out_valid;
    pop_vec_t                f_out;
    q_t                      rho;
    q_t                      u_x;
    q_t                      u_y;
    logic                    exp_push = 1'b0;
    logic [8*NAME_CHARS-1:0] exp_name = '0;
    logic [3:0]              exp_mask = '0;
    pop_vec_t                exp_f = '0;
    q_t                      exp_rho = '0;
    q_t                      exp_ux = '0;
    q_t                      exp_uy = '0;
    logic                    issue_done = 1'b0;
    logic                    check_done;
    int                      fail_count;

    int     seed = 32'h40cfa44a;
    entry_t stim [$];

    always #10 clk = ~clk;

    collider_top i_collider_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .omega     (omega),
        .f_in      (f_in),
        .out_valid (out_valid),
        .f_out     (f_out),
        .rho       (rho),
        .u_x       (u_x),
        .u_y       (u_y)
    );

    collider_checker #(
        .NAME_CHARS (NAME_CHARS)
    ) i_collider_checker (
        .clk        (clk),
        .rst        (rst),
        .out_valid  (out_valid),
        .f_out      (f_out),
        .rho        (rho),
        .u_x        (u_x),
        .u_y        (u_y),
        .exp_push   (exp_push),
        .exp_name   (exp_name),
        .exp_mask   (exp_mask),
        .exp_f      (exp_f),
        .exp_rho    (exp_rho),
        .exp_ux     (exp_ux),
        .exp_uy     (exp_uy),
        .issue_done (issue_done),
        .check_done (check_done),
        .fail_count (fail_count)
    );

    // ----------------------------------------------------------------------
    // Reference values from the lattice definitions
    // ----------------------------------------------------------------------
    function automatic q_t random_q();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic pop_vec_t random_pops();
        pop_vec_t f;
        for (int i = 0; i < NUM_DIRS; i++) begin
            f[i] = random_q();
        end
        return f;
    endfunction

    // Density wraps at 16 bits
    function automatic q_t pop_sum(pop_vec_t f);
        q_t s;
        s = '0;
        for (int i = 0; i < NUM_DIRS; i++) begin
            s = s + f[i];
        end
        return s;
    endfunction

    function automatic q_t mom_x_of(pop_vec_t f);
        return f[DIR_E] - f[DIR_W] + f[DIR_NE] - f[DIR_SW] - f[DIR_NW] + f[DIR_SE];
    endfunction

    function automatic q_t mom_y_of(pop_vec_t f);
        return f[DIR_N] - f[DIR_S] + f[DIR_NE] - f[DIR_SW] + f[DIR_NW] - f[DIR_SE];
    endfunction

    function automatic entry_t new_entry(logic [8*NAME_CHARS-1:0] name, int gap);
        entry_t e;
        e.name    = name;
        e.gap     = gap;
        e.omega   = '0;
        e.f       = '0;
        e.mask    = '0;
        e.exp_f   = '0;
        e.exp_rho = '0;
        e.exp_ux  = '0;
        e.exp_uy  = '0;
        return e;
    endfunction

    function automatic void add_density(logic [8*NAME_CHARS-1:0] name, int gap);
        entry_t e;
        e = new_entry(name, gap);
        e.f = random_pops();
        e.omega = random_q();
        e.mask[MASK_RHO] = 1'b1;
        e.exp_rho = pop_sum(e.f);
        stim.push_back(e);
    endfunction

    // Rest population absorbs the remainder so the density is exactly 1.0
    function automatic void add_unit_density(logic [8*NAME_CHARS-1:0] name, int gap);
        entry_t e;
        e = new_entry(name, gap);
        e.f = random_pops();
        e.f[DIR_NULL] = '0;
        e.f[DIR_NULL] = Q_ONE - pop_sum(e.f);
        e.omega = random_q();
        e.mask[MASK_RHO] = 1'b1;
        e.mask[MASK_UX] = 1'b1;
        e.mask[MASK_UY] = 1'b1;
        e.exp_rho = Q_ONE;
        e.exp_ux = mom_x_of(e.f);
        e.exp_uy = mom_y_of(e.f);
        stim.push_back(e);
    endfunction

    function automatic void add_zero_omega(logic [8*NAME_CHARS-1:0] name, int gap);
        entry_t e;
        e = new_entry(name, gap);
        e.f = random_pops();
        e.omega = '0;
        e.mask[MASK_F] = 1'b1;
        e.mask[MASK_RHO] = 1'b1;
        e.exp_f = e.f;
        e.exp_rho = pop_sum(e.f);
        stim.push_back(e);
    endfunction

    // Symmetric node at rest, so the equilibrium is the bare weight set
    function automatic void add_rest(logic [8*NAME_CHARS-1:0] name, int gap, q_t axis, q_t diag);
        entry_t e;
        e = new_entry(name, gap);
        e.f[DIR_N]  = axis;
        e.f[DIR_E]  = axis;
        e.f[DIR_S]  = axis;
        e.f[DIR_W]  = axis;
        e.f[DIR_NE] = diag;
        e.f[DIR_SE] = diag;
        e.f[DIR_SW] = diag;
        e.f[DIR_NW] = diag;
        e.f[DIR_NULL] = Q_ONE - pop_sum(e.f);
        e.omega = Q_ONE;
        e.mask = 4'b1111;
        e.exp_f[DIR_NULL] = W_REST;
        e.exp_f[DIR_N]    = W_AXIS;
        e.exp_f[DIR_E]    = W_AXIS;
        e.exp_f[DIR_S]    = W_AXIS;
        e.exp_f[DIR_W]    = W_AXIS;
        e.exp_f[DIR_NE]   = W_DIAG;
        e.exp_f[DIR_SE]   = W_DIAG;
        e.exp_f[DIR_SW]   = W_DIAG;
        e.exp_f[DIR_NW]   = W_DIAG;
        e.exp_rho = Q_ONE;
        stim.push_back(e);
    endfunction

    // ----------------------------------------------------------------------
    // Table build and issue loop
    // ----------------------------------------------------------------------
    initial begin
        int waited;

        add_density("density_rand_0", 1);
        add_density("density_rand_1", 0);
        add_density("density_rand_2", 0);
        add_density("density_rand_3", 2);
        add_unit_density("unit_density_0", 0);
        add_unit_density("unit_density_1", 2);
        add_unit_density("unit_density_2", 0);
        add_zero_omega("zero_omega_0", 0);
        add_zero_omega("zero_omega_1", 0);
        add_zero_omega("zero_omega_2", 3);
        add_rest("rest_relax_0", 1, 16'sh0400, 16'sh0100);
        add_rest("rest_relax_1", 0, 16'sh0300, 16'sh0200);
        add_zero_omega("stream_0", 0);
        add_unit_density("stream_1", 0);
        add_rest("stream_2", 1, 16'sh0200, 16'sh0180);
        add_density("stream_3", 0);
        add_zero_omega("stream_4", 2);
        add_unit_density("stream_5", 0);

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        foreach (stim[k]) begin
            for (int g = 0; g < stim[k].gap; g++) begin
                @(posedge clk);
                in_valid <= 1'b0;
                exp_push <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            omega    <= stim[k].omega;
            f_in     <= stim[k].f;
            exp_push <= 1'b1;
            exp_name <= stim[k].name;
            exp_mask <= stim[k].mask;
            exp_f    <= stim[k].exp_f;
            exp_rho  <= stim[k].exp_rho;
            exp_ux   <= stim[k].exp_ux;
            exp_uy   <= stim[k].exp_uy;
        end
        @(posedge clk);
        in_valid   <= 1'b0;
        exp_push   <= 1'b0;
        issue_done <= 1'b1;

        waited = 0;
        while (!check_done && waited < DONE_LIMIT) begin
            @(posedge clk);
            waited++;
        end

        if (!check_done) begin
            $display("checker did not finish within %0d cycles", DONE_LIMIT);
            $display("RESULT: FAIL");
        end else if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
common/lbm_fixed_pkg.sv
common/d2q9_pkg.sv
src/collider/stage_delay.sv
src/collider/moments.sv
src/collider/velocity.sv
src/collider/equilibrium.sv
src/collider/relaxation.sv
src/collider/collider_top.sv
dv/collider_checker.sv
dv/collider_properties.sv
dv/tb_collider.sv

// File: src/collider/collider_top.sv
`timescale 1ns/1ps

module collider_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_valid,
    input  lbm_fixed_pkg::q_t   omega,
    input  d2q9_pkg::pop_vec_t  f_in,
    output logic                out_valid,
    output d2q9_pkg::pop_vec_t  f_out,
    output lbm_fixed_pkg::q_t   rho,
    output lbm_fixed_pkg::q_t   u_x,
    output lbm_fixed_pkg::q_t   u_y
);
    import lbm_fixed_pkg::*;
    import d2q9_pkg::*;

    pop_vec_t f_lat;
    pop_vec_t f_eq;
    pop_vec_t f_prev;
    q_t       omega_lat;
    q_t       omega_relax;
    q_t       rho_m;
    q_t       mom_x;
    q_t       mom_y;
    q_t       rho_v;
    q_t       u_x_v;
    q_t       u_y_v;
    q_t       u_sq;
    q_t       ux_sq;
    q_t       uy_sq;

    moments i_moments (
        .clk       (clk),
        .rst       (rst),
        .f_in      (f_in),
        .omega     (omega),
        .f_lat     (f_lat),
        .omega_lat (omega_lat),
        .rho       (rho_m),
        .mom_x     (mom_x),
        .mom_y     (mom_y)
    );

    velocity i_velocity (
        .clk   (clk),
        .rst   (rst),
        .rho   (rho_m),
        .mom_x (mom_x),
        .mom_y (mom_y),
        .rho_d (rho_v),
        .u_x   (u_x_v),
        .u_y   (u_y_v),
        .u_sq  (u_sq),
        .ux_sq (ux_sq),
        .uy_sq (uy_sq)
    );

    equilibrium i_equilibrium (
        .clk   (clk),
        .rst   (rst),
        .u_x   (u_x_v),
        .u_y   (u_y_v),
        .u_sq  (u_sq),
        .ux_sq (ux_sq),
        .uy_sq (uy_sq),
        .f_eq  (f_eq)
    );

    relaxation i_relaxation (
        .clk    (clk),
        .rst    (rst),
        .f_prev (f_prev),
        .omega  (omega_relax),
        .f_eq   (f_eq),
        .f_out  (f_out)
    );

    // ----------------------------------------------------------------------
    // Side paths matched to the datapath latency
    // ----------------------------------------------------------------------
    stage_delay #(
        .WIDTH ($bits(pop_vec_t) + $bits(q_t)),
        .DEPTH (VELOCITY_STAGES + EQUILIBRIUM_STAGES)
    ) i_pop_delay (
        .clk  (clk),
        .rst  (rst),
        .din  ({f_lat, omega_lat}),
        .dout ({f_prev, omega_relax})
    );

    stage_delay #(
        .WIDTH (3 * $bits(q_t)),
        .DEPTH (EQUILIBRIUM_STAGES + RELAX_STAGES)
    ) i_macro_delay (
        .clk  (clk),
        .rst  (rst),
        .din  ({rho_v, u_x_v, u_y_v}),
        .dout ({rho, u_x, u_y})
    );

    stage_delay #(
        .WIDTH (1),
        .DEPTH (PIPE_STAGES)
    ) i_valid_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (in_valid),
        .dout (out_valid)
    );

endmodule

// File: src/collider/equilibrium.sv
`timescale 1ns/1ps

module equilibrium (
    input  logic                clk,
    input  logic                rst,
    input  lbm_fixed_pkg::q_t   u_x,
    input  lbm_fixed_pkg::q_t   u_y,
    input  lbm_fixed_pkg::q_t   u_sq,
    input  lbm_fixed_pkg::q_t   ux_sq,
    input  lbm_fixed_pkg::q_t   uy_sq,
    output d2q9_pkg::pop_vec_t  f_eq
);
    import lbm_fixed_pkg::*;
    import d2q9_pkg::*;

    // Stage 1 products
    q_wide_t tux_w, tuy_w, nhx_w, nhy_w, thu_w;
    q_t      xpy, xmy;
    // Stage 2
    q_t      poly_null, poly_n, poly_s, poly_e, poly_w;
    q_wide_t txpy_w, txmy_w, sqpy_w, sqmy_w;
    q_t      thu_s2;
    // Stage 3
    q_wide_t wnull_w, wn_w, ws_w, we_w, ww_w;
    q_wide_t nhpy_w, nhmy_w;
    q_t      txpy_s3, txmy_s3, thu_s3;
    // Stage 4
    q_t      eq_null, eq_n, eq_s, eq_e, eq_w;
    q_t      poly_ne, poly_sw, poly_se, poly_nw;

    q_t tux, tuy, nhx, nhy, thu, nhpy, nhmy;

    assign tux  = q_t'(tux_w >>> FRAC_BITS);
    assign tuy  = q_t'(tuy_w >>> FRAC_BITS);
    assign nhx  = q_t'(nhx_w >>> FRAC_BITS);
    assign nhy  = q_t'(nhy_w >>> FRAC_BITS);
    assign thu  = q_t'(thu_w >>> FRAC_BITS);
    assign nhpy = q_t'(nhpy_w >>> FRAC_BITS);
    assign nhmy = q_t'(nhmy_w >>> FRAC_BITS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {tux_w, tuy_w, nhx_w, nhy_w, thu_w} <= '0;
            {xpy, xmy} <= '0;
            {poly_null, poly_n, poly_s, poly_e, poly_w} <= '0;
            {txpy_w, txmy_w, sqpy_w, sqmy_w} <= '0;
            thu_s2 <= '0;
            {wnull_w, wn_w, ws_w, we_w, ww_w} <= '0;
            {nhpy_w, nhmy_w} <= '0;
            {txpy_s3, txmy_s3, thu_s3} <= '0;
            {eq_null, eq_n, eq_s, eq_e, eq_w} <= '0;
            {poly_ne, poly_sw, poly_se, poly_nw} <= '0;
            f_eq <= '0;
        end else begin
            // 3u, (9/2)u^2 by doubling before 9/4, (3/2)|u|^2
            tux_w <= Q_THREE * u_x;
            tuy_w <= Q_THREE * u_y;
            nhx_w <= Q_NINE_QUARTERS * q_t'(ux_sq <<< 1);
            nhy_w <= Q_NINE_QUARTERS * q_t'(uy_sq <<< 1);
            thu_w <= Q_THREE_HALVES * u_sq;
            xpy   <= u_x + u_y;
            xmy   <= u_x - u_y;

            // ----------------------------------------------------------------
            // Rest and axis polynomials, diagonal products
            // ----------------------------------------------------------------
            poly_null <= Q_ONE - thu;
            poly_n    <= Q_ONE + tuy + nhy - thu;
            poly_s    <= Q_ONE - tuy + nhy - thu;
            poly_e    <= Q_ONE + tux + nhx - thu;
            poly_w    <= Q_ONE - tux + nhx - thu;
            txpy_w    <= Q_THREE * xpy;
            txmy_w    <= Q_THREE * xmy;
            sqpy_w    <= xpy * xpy;
            sqmy_w    <= xmy * xmy;
            thu_s2    <= thu;

            // Axis weights; diagonal square shifted one less to double it
            wnull_w <= W_REST * poly_null;
            wn_w    <= W_AXIS * poly_n;
            ws_w    <= W_AXIS * poly_s;
            we_w    <= W_AXIS * poly_e;
            ww_w    <= W_AXIS * poly_w;
            nhpy_w  <= Q_NINE_QUARTERS * q_t'(sqpy_w >>> (FRAC_BITS - 1));
            nhmy_w  <= Q_NINE_QUARTERS * q_t'(sqmy_w >>> (FRAC_BITS - 1));
            txpy_s3 <= q_t'(txpy_w >>> FRAC_BITS);
            txmy_s3 <= q_t'(txmy_w >>> FRAC_BITS);
            thu_s3  <= thu_s2;

            // ----------------------------------------------------------------
            // Diagonal polynomials, SE and NW lie along x - y
            // ----------------------------------------------------------------
            eq_null <= q_t'(wnull_w >>> FRAC_BITS);
            eq_n    <= q_t'(wn_w >>> FRAC_BITS);
            eq_s    <= q_t'(ws_w >>> FRAC_BITS);
            eq_e    <= q_t'(we_w >>> FRAC_BITS);
            eq_w    <= q_t'(ww_w >>> FRAC_BITS);
            poly_ne <= Q_ONE + txpy_s3 + nhpy - thu_s3;
            poly_sw <= Q_ONE - txpy_s3 + nhpy - thu_s3;
            poly_se <= Q_ONE + txmy_s3 + nhmy - thu_s3;
            poly_nw <= Q_ONE - txmy_s3 + nhmy - thu_s3;

            f_eq[DIR_NULL] <= eq_null;
            f_eq[DIR_N]    <= eq_n;
            f_eq[DIR_S]    <= eq_s;
            f_eq[DIR_E]    <= eq_e;
            f_eq[DIR_W]    <= eq_w;
            f_eq[DIR_NE]   <= q_mul(W_DIAG, poly_ne);
            f_eq[DIR_SW]   <= q_mul(W_DIAG, poly_sw);
            f_eq[DIR_SE]   <= q_mul(W_DIAG, poly_se);
            f_eq[DIR_NW]   <= q_mul(W_DIAG, poly_nw);
        end
    end

endmodule

// File: src/collider/moments.sv
`timescale 1ns/1ps

module moments (
    input  logic                clk,
    input  logic                rst,
    input  d2q9_pkg::pop_vec_t  f_in,
    input  lbm_fixed_pkg::q_t   omega,
    output d2q9_pkg::pop_vec_t  f_lat,
    output lbm_fixed_pkg::q_t   omega_lat,
    output lbm_fixed_pkg::q_t   rho,
    output lbm_fixed_pkg::q_t   mom_x,
    output lbm_fixed_pkg::q_t   mom_y
);
    import lbm_fixed_pkg::*;
    import d2q9_pkg::*;

    pop_vec_t f_s1;
    q_t       omega_s1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            f_s1      <= '0;
            omega_s1  <= '0;
            f_lat     <= '0;
            omega_lat <= '0;
            rho       <= '0;
            mom_x     <= '0;
            mom_y     <= '0;
        end else begin
            // Input latch
            f_s1     <= f_in;
            omega_s1 <= omega;

            // Zeroth and first moments, wrapping at 16 bits
            f_lat     <= f_s1;
            omega_lat <= omega_s1;
            rho   <= f_s1[DIR_NULL] + f_s1[DIR_N] + f_s1[DIR_NE] + f_s1[DIR_E] +
                     f_s1[DIR_SE] + f_s1[DIR_S] + f_s1[DIR_SW] + f_s1[DIR_W] +
                     f_s1[DIR_NW];
            mom_x <= f_s1[DIR_E] - f_s1[DIR_W] + f_s1[DIR_NE] - f_s1[DIR_SW] -
                     f_s1[DIR_NW] + f_s1[DIR_SE];
            mom_y <= f_s1[DIR_N] - f_s1[DIR_S] + f_s1[DIR_NE] - f_s1[DIR_SW] +
                     f_s1[DIR_NW] - f_s1[DIR_SE];
        end
    end

endmodule

// File: src/collider/relaxation.sv
`timescale 1ns/1ps

module relaxation (
    input  logic                clk,
    input  logic                rst,
    input  d2q9_pkg::pop_vec_t  f_prev,
    input  lbm_fixed_pkg::q_t   omega,
    input  d2q9_pkg::pop_vec_t  f_eq,
    output d2q9_pkg::pop_vec_t  f_out
);
    import lbm_fixed_pkg::*;
    import d2q9_pkg::*;

    q_wide_t  delta [NUM_DIRS];
    pop_vec_t f_hold;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_DIRS; i++) begin
                delta[i] <= '0;
            end
            f_hold <= '0;
            f_out  <= '0;
        end else begin
            f_hold <= f_prev;
            for (int i = 0; i < NUM_DIRS; i++) begin
                // BGK correction, difference kept at full width
                delta[i] <= omega * ($signed(f_eq[i]) - $signed(f_prev[i]));
                f_out[i] <= f_hold[i] + q_t'(delta[i] >>> FRAC_BITS);
            end
        end
    end

endmodule

// File: src/collider/stage_delay.sv
`timescale 1ns/1ps

module stage_delay #(
    parameter int WIDTH = 16,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] pipe [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign dout = pipe[DEPTH-1];

endmodule

// File: src/collider/velocity.sv
`timescale 1ns/1ps

module velocity (
    input  logic               clk,
    input  logic               rst,
    input  lbm_fixed_pkg::q_t  rho,
    input  lbm_fixed_pkg::q_t  mom_x,
    input  lbm_fixed_pkg::q_t  mom_y,
    output lbm_fixed_pkg::q_t  rho_d,
    output lbm_fixed_pkg::q_t  u_x,
    output lbm_fixed_pkg::q_t  u_y,
    output lbm_fixed_pkg::q_t  u_sq,
    output lbm_fixed_pkg::q_t  ux_sq,
    output lbm_fixed_pkg::q_t  uy_sq
);
    import lbm_fixed_pkg::*;

    // Carried alongside the reciprocal
    q_t      rho_p   [7];
    q_t      mom_x_p [4];
    q_t      mom_y_p [4];

    q_t      x1;
    q_t      x1_s1;
    q_t      x2_s3;
    q_wide_t p1;
    q_wide_t x2;
    q_wide_t p2;
    q_wide_t x3;
    q_wide_t ux_w;
    q_wide_t uy_w;
    q_t      ux_s6;
    q_t      uy_s6;
    q_t      ux_s7;
    q_t      uy_s7;
    q_wide_t ux2_w;
    q_wide_t uy2_w;

    // Initial guess for 1/rho
    assign x1 = Q_TWO - rho;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 7; i++) begin
                rho_p[i] <= '0;
            end
            for (int i = 0; i < 4; i++) begin
                mom_x_p[i] <= '0;
                mom_y_p[i] <= '0;
            end
            x1_s1 <= '0;
            x2_s3 <= '0;
            p1    <= '0;
            x2    <= '0;
            p2    <= '0;
            x3    <= '0;
            ux_w  <= '0;
            uy_w  <= '0;
            ux_s6 <= '0;
            uy_s6 <= '0;
            ux_s7 <= '0;
            uy_s7 <= '0;
            ux2_w <= '0;
            uy2_w <= '0;
            rho_d <= '0;
            u_x   <= '0;
            u_y   <= '0;
            u_sq  <= '0;
            ux_sq <= '0;
            uy_sq <= '0;
        end else begin
            rho_p[0]   <= rho;
            mom_x_p[0] <= mom_x;
            mom_y_p[0] <= mom_y;
            for (int i = 1; i < 7; i++) begin
                rho_p[i] <= rho_p[i-1];
            end
            for (int i = 1; i < 4; i++) begin
                mom_x_p[i] <= mom_x_p[i-1];
                mom_y_p[i] <= mom_y_p[i-1];
            end

            // --------------------------------------------------------------
            // Newton-Raphson, x(k+1) = x(k) * (2 - rho * x(k))
            // --------------------------------------------------------------
            x1_s1 <= x1;
            p1    <= rho * x1;
            x2    <= x1_s1 * q_t'(Q_TWO - q_t'(p1 >>> FRAC_BITS));
            x2_s3 <= q_t'(x2 >>> FRAC_BITS);
            p2    <= rho_p[1] * q_t'(x2 >>> FRAC_BITS);
            x3    <= x2_s3 * q_t'(Q_TWO - q_t'(p2 >>> FRAC_BITS));

            // u = rho*u times 1/rho
            ux_w  <= mom_x_p[3] * q_t'(x3 >>> FRAC_BITS);
            uy_w  <= mom_y_p[3] * q_t'(x3 >>> FRAC_BITS);
            ux_s6 <= q_t'(ux_w >>> FRAC_BITS);
            uy_s6 <= q_t'(uy_w >>> FRAC_BITS);

            // Squared terms
            ux2_w <= ux_s6 * ux_s6;
            uy2_w <= uy_s6 * uy_s6;
            ux_s7 <= ux_s6;
            uy_s7 <= uy_s6;
            ux_sq <= q_t'(ux2_w >>> FRAC_BITS);
            uy_sq <= q_t'(uy2_w >>> FRAC_BITS);
            u_sq  <= q_t'((ux2_w + uy2_w) >>> FRAC_BITS);
            u_x   <= ux_s7;
            u_y   <= uy_s7;
            rho_d <= rho_p[6];
        end
    end

endmodule
